//--- apb_sub_settings.svh
// APB subsystem settings: slot address map, ALUT register offsets and table depth
`ifndef APB_SUB_SETTINGS_SVH
`define APB_SUB_SETTINGS_SVH

// --------------------
// Slot address ranges
// --------------------
// Slot 0, address lookup table
`define SLOT0_BASE 32'h00A0_0000
`define SLOT0_LAST 32'h00A0_FFFF
// Slots 1 to 4, MAC0 to MAC3 register blocks
`define SLOT1_BASE 32'h00A1_0000
`define SLOT1_LAST 32'h00A1_FFFF
`define SLOT2_BASE 32'h00A2_0000
`define SLOT2_LAST 32'h00A2_FFFF
`define SLOT3_BASE 32'h00A3_0000
`define SLOT3_LAST 32'h00A3_FFFF
`define SLOT4_BASE 32'h00A4_0000
`define SLOT4_LAST 32'h00A4_FFFF

// --------------------
// ALUT registers
// --------------------
// Table entries, power of two
`define ALUT_DEPTH 8
`define ALUT_CMD 7'h00
`define ALUT_MAC_LO 7'h04
`define ALUT_MAC_HI 7'h08
`define ALUT_PORT 7'h0C
`define ALUT_RESULT 7'h10
`define ALUT_COUNT 7'h14

`endif

//--- apb_sub_pkg.sv
// APB subsystem types shared by the bridge and the address lookup table
package apb_sub_pkg;

   // --------------------
   // AHB side
   // --------------------
   // htrans encoding
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } ahb_trans_t;

   // --------------------
   // APB side
   // --------------------
   // Bridge sequencing states
   typedef enum logic [1:0] {
      AP_IDLE   = 2'b00,
      AP_SETUP  = 2'b01,
      AP_ACCESS = 2'b10,
      AP_ERR    = 2'b11
   } apb_phase_t;

   // Slot index, 0 to 4 valid, 7 for no match
   typedef logic [2:0] slot_t;

   // One address table entry
   typedef struct packed {
      logic        valid;
      logic [47:0] mac;
      logic [1:0]  port;
   } alut_entry_t;

endpackage

//--- ahb_apb_bridge.sv
// AHB-lite slave bridging single transfers onto a five-slot APB bus
`timescale 1ns/100ps
`include "apb_sub_settings.svh"

module ahb_apb_bridge (
   input  logic        hclk,
   input  logic        rst,
   // AHB-lite slave side
   input  logic        hsel,
   input  logic [31:0] haddr,
   input  logic [1:0]  htrans,
   input  logic        hwrite,
   input  logic [31:0] hwdata,
   input  logic        hready_in,
   output logic [31:0] hrdata,
   output logic        hready,
   output logic [1:0]  hresp,
   // APB master side, shared
   output logic [31:0] paddr,
   output logic        pwrite,
   output logic [31:0] pwdata,
   output logic        penable,
   // Slot selects
   output logic        psel_alut,
   output logic        psel_mac0,
   output logic        psel_mac1,
   output logic        psel_mac2,
   output logic        psel_mac3,
   // Slot read data
   input  logic [31:0] prdata_alut,
   input  logic [31:0] prdata_mac0,
   input  logic [31:0] prdata_mac1,
   input  logic [31:0] prdata_mac2,
   input  logic [31:0] prdata_mac3,
   // Slot ready, ALUT is always ready
   input  logic        pready_mac0,
   input  logic        pready_mac1,
   input  logic        pready_mac2,
   input  logic        pready_mac3
);
   import apb_sub_pkg::*;

   localparam slot_t      SLOT_NONE  = 3'd7;
   localparam logic [1:0] RESP_OKAY  = 2'b00;
   localparam logic [1:0] RESP_ERROR = 2'b01;

   apb_phase_t  state;
   ahb_trans_t  trans;
   slot_t       slot;
   logic        start;
   logic        apb_active;
   logic        pready_sel;
   logic        pready_alut;
   logic [31:0] prdata_sel;
   logic [31:0] pwdata_q;

   // Address map lookup
   function automatic slot_t decode(input logic [31:0] addr);
      slot_t s;
      s = SLOT_NONE;
      if (addr >= `SLOT0_BASE && addr <= `SLOT0_LAST) s = 3'd0;
      if (addr >= `SLOT1_BASE && addr <= `SLOT1_LAST) s = 3'd1;
      if (addr >= `SLOT2_BASE && addr <= `SLOT2_LAST) s = 3'd2;
      if (addr >= `SLOT3_BASE && addr <= `SLOT3_LAST) s = 3'd3;
      if (addr >= `SLOT4_BASE && addr <= `SLOT4_LAST) s = 3'd4;
      return s;
   endfunction

   // --------------------
   // Address phase
   // --------------------
   assign trans = ahb_trans_t'(htrans);
   // Valid transfer seen at this edge
   assign start = hsel && hready_in && hready && (trans == NONSEQ || trans == SEQ);

   // Address and direction held for the whole APB cycle
   always_ff @(posedge hclk) begin
      if (start) begin
         paddr  <= haddr;
         pwrite <= hwrite;
      end
   end

   // Slot of the captured address
   assign slot = decode(paddr);

   // --------------------
   // Phase FSM
   // --------------------
   always_ff @(posedge hclk) begin
      if (rst) begin
         state <= AP_IDLE;
      end else begin
         case (state)
            AP_IDLE, AP_ERR: state <= start ? AP_SETUP : AP_IDLE;
            // Unmapped address turns setup into first error cycle
            AP_SETUP: state <= (slot == SLOT_NONE) ? AP_ERR : AP_ACCESS;
            AP_ACCESS: begin
               // Stay while slot stretches the access
               if (pready_sel) state <= start ? AP_SETUP : AP_IDLE;
            end
            default: state <= AP_IDLE;
         endcase
      end
   end

   // Write data arrives during setup, held afterwards
   always_ff @(posedge hclk) begin
      if (state == AP_SETUP) pwdata_q <= hwdata;
   end
   assign pwdata = (state == AP_SETUP) ? hwdata : pwdata_q;

   // --------------------
   // APB outputs
   // --------------------
   assign apb_active = (state == AP_SETUP) || (state == AP_ACCESS);
   assign penable    = (state == AP_ACCESS);
   assign psel_alut  = apb_active && (slot == 3'd0);
   assign psel_mac0  = apb_active && (slot == 3'd1);
   assign psel_mac1  = apb_active && (slot == 3'd2);
   assign psel_mac2  = apb_active && (slot == 3'd3);
   assign psel_mac3  = apb_active && (slot == 3'd4);

   // ALUT answers in one access cycle
   assign pready_alut = 1'b1;

   // Read data and ready of addressed slot
   always_comb begin
      case (slot)
         3'd0:    {pready_sel, prdata_sel} = {pready_alut, prdata_alut};
         3'd1:    {pready_sel, prdata_sel} = {pready_mac0, prdata_mac0};
         3'd2:    {pready_sel, prdata_sel} = {pready_mac1, prdata_mac1};
         3'd3:    {pready_sel, prdata_sel} = {pready_mac2, prdata_mac2};
         3'd4:    {pready_sel, prdata_sel} = {pready_mac3, prdata_mac3};
         default: {pready_sel, prdata_sel} = {1'b1, 32'h0};
      endcase
   end

   // --------------------
   // AHB response
   // --------------------
   always_comb begin
      case (state)
         AP_SETUP:  hready = 1'b0;
         AP_ACCESS: hready = pready_sel;
         default:   hready = 1'b1;
      endcase
   end

   // ERROR low then ERROR high for unmapped addresses
   assign hresp = ((state == AP_SETUP && slot == SLOT_NONE) || state == AP_ERR) ?
                  RESP_ERROR : RESP_OKAY;

   assign hrdata = prdata_sel;

endmodule

//--- alut_regs.sv
// ALUT register block: operand registers, command decode and result capture
`timescale 1ns/100ps
`include "apb_sub_settings.svh"

module alut_regs (
   input  logic        hclk,
   input  logic        rst,
   // APB slave
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   // Table side
   input  logic        busy,
   input  logic        done,
   input  logic        hit,
   input  logic [1:0]  hit_port,
   input  logic [$clog2(`ALUT_DEPTH):0] entry_count,
   output logic        learn_req,
   output logic        lookup_req,
   output logic [47:0] key_mac,
   output logic [1:0]  key_port
);
   import apb_sub_pkg::*;

   logic        reg_wr;
   logic        cmd_wr;
   logic [31:0] mac_lo;
   logic [15:0] mac_hi;
   logic [1:0]  port_q;
   // Hit and port of the last finished command
   logic        result_hit;
   logic [1:0]  result_port;

   // Access cycle write, slot has no wait states
   assign reg_wr = psel && penable && pwrite;
   // Commands ignored during a scan
   assign cmd_wr = reg_wr && (paddr == `ALUT_CMD) && !busy;

   // Bit 0 learn, bit 1 lookup
   assign learn_req  = cmd_wr && pwdata[0];
   assign lookup_req = cmd_wr && pwdata[1];

   assign key_mac  = {mac_hi, mac_lo};
   assign key_port = port_q;

   // --------------------
   // Register writes
   // --------------------
   always_ff @(posedge hclk) begin
      if (rst) begin
         mac_lo      <= '0;
         mac_hi      <= '0;
         port_q      <= '0;
         result_hit  <= 1'b0;
         result_port <= '0;
      end else begin
         if (reg_wr) begin
            case (paddr)
               `ALUT_MAC_LO: mac_lo <= pwdata;
               `ALUT_MAC_HI: mac_hi <= pwdata[15:0];
               `ALUT_PORT:   port_q <= pwdata[1:0];
               default:      ;
            endcase
         end
         // Result of the finished learn or lookup
         if (done) begin
            result_hit  <= hit;
            result_port <= hit_port;
         end
      end
   end

   // --------------------
   // Read mux
   // --------------------
   always_comb begin
      prdata = '0;
      case (paddr)
         `ALUT_CMD:    prdata[0] = busy;
         `ALUT_MAC_LO: prdata = mac_lo;
         `ALUT_MAC_HI: prdata[15:0] = mac_hi;
         `ALUT_PORT:   prdata[1:0] = port_q;
         `ALUT_RESULT: prdata[2:0] = {result_hit, result_port};
         `ALUT_COUNT:  prdata[$clog2(`ALUT_DEPTH):0] = entry_count;
         default:      prdata = '0;
      endcase
   end

endmodule

//--- alut_table.sv
// ALUT storage with single-cycle learn and a sequential lookup scan
`timescale 1ns/100ps
`include "apb_sub_settings.svh"

module alut_table (
   input  logic        hclk,
   input  logic        rst,
   input  logic        learn_req,
   input  logic        lookup_req,
   input  logic [47:0] key_mac,
   input  logic [1:0]  key_port,
   output logic        busy,
   output logic        done,
   output logic        hit,
   output logic [1:0]  hit_port,
   output logic [$clog2(`ALUT_DEPTH):0] entry_count
);
   import apb_sub_pkg::*;

   localparam int DEPTH = `ALUT_DEPTH;
   localparam int IW    = $clog2(DEPTH);

   alut_entry_t     tbl [DEPTH];
   logic            match_any;
   logic            free_any;
   logic [IW-1:0]   match_idx;
   logic [IW-1:0]   free_idx;
   logic [IW-1:0]   scan_idx;
   // Key held for the duration of a scan
   logic [47:0]     scan_mac;

   // --------------------
   // Learn search
   // --------------------
   // Lowest matching and lowest free entry
   always_comb begin
      match_any = 1'b0;
      match_idx = '0;
      free_any  = 1'b0;
      free_idx  = '0;
      for (int i = DEPTH - 1; i >= 0; i--) begin
         if (tbl[i].valid && tbl[i].mac == key_mac) begin
            match_any = 1'b1;
            match_idx = IW'(i);
         end
         if (!tbl[i].valid) begin
            free_any = 1'b1;
            free_idx = IW'(i);
         end
      end
   end

   // --------------------
   // Learn and lookup
   // --------------------
   always_ff @(posedge hclk) begin
      if (rst) begin
         busy        <= 1'b0;
         done        <= 1'b0;
         hit         <= 1'b0;
         hit_port    <= '0;
         entry_count <= '0;
         scan_idx    <= '0;
         // Only valid bits need clearing
         for (int i = 0; i < DEPTH; i++) tbl[i].valid <= 1'b0;
      end else begin
         done <= 1'b0;
         // Learn wins when both are requested
         if (learn_req && !busy) begin
            done     <= 1'b1;
            hit_port <= key_port;
            if (match_any) begin
               // Existing MAC moves to new port
               tbl[match_idx].port <= key_port;
               hit <= 1'b1;
            end else if (free_any) begin
               tbl[free_idx] <= '{valid: 1'b1, mac: key_mac, port: key_port};
               entry_count   <= entry_count + 1'b1;
               hit <= 1'b1;
            end else begin
               // Full table, learn dropped
               hit <= 1'b0;
            end
         end else if (lookup_req && !busy) begin
            busy     <= 1'b1;
            scan_idx <= '0;
            scan_mac <= key_mac;
         end else if (busy) begin
            // One entry per cycle
            if (tbl[scan_idx].valid && tbl[scan_idx].mac == scan_mac) begin
               busy     <= 1'b0;
               done     <= 1'b1;
               hit      <= 1'b1;
               hit_port <= tbl[scan_idx].port;
            end else if (scan_idx == IW'(DEPTH - 1)) begin
               busy <= 1'b0;
               done <= 1'b1;
               hit  <= 1'b0;
            end else begin
               scan_idx <= scan_idx + 1'b1;
            end
         end
      end
   end

endmodule

//--- apb_subsystem.sv
// Peripheral subsystem: AHB-lite to APB bridge, ALUT and four external MAC slots
`timescale 1ns/100ps
`include "apb_sub_settings.svh"

module apb_subsystem (
   input  logic        hclk,
   input  logic        rst,
   // AHB-lite slave
   input  logic        hsel,
   input  logic [31:0] haddr,
   input  logic [1:0]  htrans,
   input  logic        hwrite,
   input  logic [31:0] hwdata,
   input  logic        hready_in,
   output logic [31:0] hrdata,
   output logic        hready,
   output logic [1:0]  hresp,
   // APB shared
   output logic [31:0] paddr,
   output logic        pwrite,
   output logic        penable,
   output logic [31:0] pwdata,
   // MAC0
   input  logic [31:0] prdata_mac0,
   output logic        psel_mac0,
   input  logic        pready_mac0,
   // MAC1
   input  logic [31:0] prdata_mac1,
   output logic        psel_mac1,
   input  logic        pready_mac1,
   // MAC2
   input  logic [31:0] prdata_mac2,
   output logic        psel_mac2,
   input  logic        pready_mac2,
   // MAC3
   input  logic [31:0] prdata_mac3,
   output logic        psel_mac3,
   input  logic        pready_mac3
);

   // --------------------
   // Internal ALUT slot
   // --------------------
   logic        psel_alut;
   logic [31:0] prdata_alut;
   logic        learn_req;
   logic        lookup_req;
   logic [47:0] key_mac;
   logic [1:0]  key_port;
   logic        busy;
   logic        done;
   logic        hit;
   logic [1:0]  hit_port;
   logic [$clog2(`ALUT_DEPTH):0] entry_count;

   ahb_apb_bridge i_bridge (
      .hclk        (hclk),
      .rst         (rst),
      .hsel        (hsel),
      .haddr       (haddr),
      .htrans      (htrans),
      .hwrite      (hwrite),
      .hwdata      (hwdata),
      .hready_in   (hready_in),
      .hrdata      (hrdata),
      .hready      (hready),
      .hresp       (hresp),
      .paddr       (paddr),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .penable     (penable),
      .psel_alut   (psel_alut),
      .psel_mac0   (psel_mac0),
      .psel_mac1   (psel_mac1),
      .psel_mac2   (psel_mac2),
      .psel_mac3   (psel_mac3),
      .prdata_alut (prdata_alut),
      .prdata_mac0 (prdata_mac0),
      .prdata_mac1 (prdata_mac1),
      .prdata_mac2 (prdata_mac2),
      .prdata_mac3 (prdata_mac3),
      .pready_mac0 (pready_mac0),
      .pready_mac1 (pready_mac1),
      .pready_mac2 (pready_mac2),
      .pready_mac3 (pready_mac3)
   );

   // Register block sees low address bits only
   alut_regs i_alut_regs (
      .hclk        (hclk),
      .rst         (rst),
      .psel        (psel_alut),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr[6:0]),
      .pwdata      (pwdata),
      .prdata      (prdata_alut),
      .busy        (busy),
      .done        (done),
      .hit         (hit),
      .hit_port    (hit_port),
      .entry_count (entry_count),
      .learn_req   (learn_req),
      .lookup_req  (lookup_req),
      .key_mac     (key_mac),
      .key_port    (key_port)
   );

   alut_table i_alut_table (
      .hclk        (hclk),
      .rst         (rst),
      .learn_req   (learn_req),
      .lookup_req  (lookup_req),
      .key_mac     (key_mac),
      .key_port    (key_port),
      .busy        (busy),
      .done        (done),
      .hit         (hit),
      .hit_port    (hit_port),
      .entry_count (entry_count)
   );

endmodule

//--- tb_mac_model.sv
// Behavioral MAC register slave on APB, one data register with random wait states
`timescale 1ns/100ps

module tb_mac_model #(
   // Slot number folded into read data
   parameter logic [31:0] SLOT = 32'd1
) (
   input  logic        hclk,
   input  logic        rst,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready
);

   logic [31:0] store;
   // Access cycles still to stretch
   logic [1:0]  wait_cnt;

   assign pready = (wait_cnt == 2'd0);
   // Read data marks which slot answered
   assign prdata = store ^ SLOT;

   always @(posedge hclk) begin
      if (rst) begin
         store    <= 32'h0;
         wait_cnt <= 2'd0;
      end else if (psel && !penable) begin
         // Setup cycle, pick 0 to 3 wait states
         wait_cnt <= 2'($urandom % 4);
      end else if (psel && penable) begin
         if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end else if (pwrite) begin
            store <= pwdata;
         end
      end
   end

endmodule

//--- tb_apb_subsystem.sv
// Testbench for the APB subsystem: AHB driver, ALUT and MAC slot checks, watchdog
`timescale 1ns/100ps
`include "apb_sub_settings.svh"

module tb_apb_subsystem;
   import apb_sub_pkg::*;

   localparam int          CLK_PERIOD = 100;
   // Upper bound on AHB transfers issued by all tests
   localparam int          MAX_XFERS  = 400;
   localparam int          HREADY_MAX = 16;
   localparam int          POLL_MAX   = 4 * `ALUT_DEPTH;
   localparam logic [31:0] SEED       = 32'hd451399a;
   localparam logic [1:0]  RESP_OKAY  = 2'b00;
   localparam logic [1:0]  RESP_ERROR = 2'b01;

   logic        hclk;
   logic        rst;
   logic        hsel;
   logic [31:0] haddr;
   logic [1:0]  htrans;
   logic        hwrite;
   logic [31:0] hwdata;
   logic        hready_in;
   logic [31:0] hrdata;
   logic        hready;
   logic [1:0]  hresp;
   logic [31:0] paddr;
   logic        pwrite;
   logic        penable;
   logic [31:0] pwdata;
   logic [31:0] prdata_mac0;
   logic [31:0] prdata_mac1;
   logic [31:0] prdata_mac2;
   logic [31:0] prdata_mac3;
   logic        psel_mac0;
   logic        psel_mac1;
   logic        psel_mac2;
   logic        psel_mac3;
   logic        pready_mac0;
   logic        pready_mac1;
   logic        pready_mac2;
   logic        pready_mac3;
   logic [3:0]  psel_vec;
   logic [3:0]  pready_vec;

   // Bookkeeping
   int          errors     = 0;
   int          checks     = 0;
   int          tests      = 0;
   int          test_base  = 0;
   int          xfer_count = 0;
   logic        in_xfer    = 1'b0;
   logic [3:0]  exp_psel   = 4'b0000;
   logic        exp_alut   = 1'b0;
   logic [31:0] exp_addr   = 32'h0;
   logic        exp_write  = 1'b0;
   // Reference copy of the address table, in fill order
   logic [47:0] ref_mac [$];
   logic [1:0]  ref_port [$];

   initial hclk = 1'b0;
   always #(CLK_PERIOD / 2) hclk = ~hclk;

   assign psel_vec   = {psel_mac3, psel_mac2, psel_mac1, psel_mac0};
   assign pready_vec = {pready_mac3, pready_mac2, pready_mac1, pready_mac0};

   // --------------------
   // DUT and MAC models
   // --------------------
   apb_subsystem uut (
      .hclk(hclk), .rst(rst), .hsel(hsel), .haddr(haddr), .htrans(htrans),
      .hwrite(hwrite), .hwdata(hwdata), .hready_in(hready_in), .hrdata(hrdata),
      .hready(hready), .hresp(hresp), .paddr(paddr), .pwrite(pwrite),
      .penable(penable), .pwdata(pwdata),
      .prdata_mac0(prdata_mac0), .psel_mac0(psel_mac0), .pready_mac0(pready_mac0),
      .prdata_mac1(prdata_mac1), .psel_mac1(psel_mac1), .pready_mac1(pready_mac1),
      .prdata_mac2(prdata_mac2), .psel_mac2(psel_mac2), .pready_mac2(pready_mac2),
      .prdata_mac3(prdata_mac3), .psel_mac3(psel_mac3), .pready_mac3(pready_mac3)
   );

   tb_mac_model #(.SLOT(32'd1)) mac0 (.hclk(hclk), .rst(rst), .psel(psel_mac0),
      .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata_mac0),
      .pready(pready_mac0));
   tb_mac_model #(.SLOT(32'd2)) mac1 (.hclk(hclk), .rst(rst), .psel(psel_mac1),
      .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata_mac1),
      .pready(pready_mac1));
   tb_mac_model #(.SLOT(32'd3)) mac2 (.hclk(hclk), .rst(rst), .psel(psel_mac2),
      .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata_mac2),
      .pready(pready_mac2));
   tb_mac_model #(.SLOT(32'd4)) mac3 (.hclk(hclk), .rst(rst), .psel(psel_mac3),
      .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata_mac3),
      .pready(pready_mac3));

   // --------------------
   // Helpers
   // --------------------
   // MAC select expected for an address, ALUT and holes give none
   function automatic logic [3:0] expect_psel(input logic [31:0] addr);
      logic [3:0] v;
      v = 4'b0000;
      if (addr >= `SLOT1_BASE && addr <= `SLOT1_LAST) v = 4'b0001;
      if (addr >= `SLOT2_BASE && addr <= `SLOT2_LAST) v = 4'b0010;
      if (addr >= `SLOT3_BASE && addr <= `SLOT3_LAST) v = 4'b0100;
      if (addr >= `SLOT4_BASE && addr <= `SLOT4_LAST) v = 4'b1000;
      return v;
   endfunction

   function automatic logic [31:0] alut_addr(input logic [6:0] off);
      return `SLOT0_BASE + 32'(off);
   endfunction

   function automatic int ref_find(input logic [47:0] mac);
      int idx;
      idx = -1;
      foreach (ref_mac[i]) begin
         if (ref_mac[i] == mac && idx < 0) idx = i;
      end
      return idx;
   endfunction

   // Update in place, else append while room is left
   task automatic ref_learn(input logic [47:0] mac, input logic [1:0] port);
      int idx;
      idx = ref_find(mac);
      if (idx >= 0) begin
         ref_port[idx] = port;
      end else if (ref_mac.size() < `ALUT_DEPTH) begin
         ref_mac.push_back(mac);
         ref_port.push_back(port);
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] want);
      checks++;
      assert (got == want) else begin
         $display("[ERROR] %0t %s: got 0x%08h expected 0x%08h", $time, name, got, want);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == test_base) $display("Test %0d %s: ok", tests, name);
      else $display("Test %0d %s: %0d errors", tests, name, errors - test_base);
      test_base = errors;
   endtask

   // --------------------
   // AHB driver
   // --------------------
   // Entered and left 1 ns after a rising edge
   task automatic ahb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic [1:0] resp);
      int waits;
      waits = 0;
      xfer_count++;
      hsel   = 1'b1;
      htrans = NONSEQ;
      haddr  = addr;
      hwrite = wr;
      @(posedge hclk);
      #1;
      // Data phase, write data goes out with the APB setup cycle
      hsel      = 1'b0;
      htrans    = IDLE;
      hwdata    = wdata;
      exp_psel  = expect_psel(addr);
      exp_alut  = (addr >= `SLOT0_BASE && addr <= `SLOT0_LAST);
      exp_addr  = addr;
      exp_write = wr;
      in_xfer   = 1'b1;
      @(negedge hclk);
      while (!hready && waits < HREADY_MAX) begin
         waits++;
         @(negedge hclk);
      end
      assert (hready) else begin
         $display("Transfer to 0x%08h never completed, hready stayed low", addr);
         errors++;
      end
      rdata = hrdata;
      resp  = hresp;
      @(posedge hclk);
      #1;
      in_xfer = 1'b0;
   endtask

   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic [1:0]  resp;
      ahb_xfer(1'b1, addr, data, rd, resp);
      check_val("hresp", 32'(resp), 32'(RESP_OKAY));
   endtask

   task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
      logic [1:0] resp;
      ahb_xfer(1'b0, addr, 32'h0, data, resp);
      check_val("hresp", 32'(resp), 32'(RESP_OKAY));
   endtask

   task automatic alut_learn(input logic [47:0] mac, input logic [1:0] port);
      write_reg(alut_addr(`ALUT_MAC_LO), mac[31:0]);
      write_reg(alut_addr(`ALUT_MAC_HI), 32'(mac[47:32]));
      write_reg(alut_addr(`ALUT_PORT), 32'(port));
      write_reg(alut_addr(`ALUT_CMD), 32'h1);
      ref_learn(mac, port);
   endtask

   // Lookup, poll busy, compare RESULT with the reference table
   task automatic alut_lookup_check(input logic [47:0] mac);
      logic [31:0] rd;
      int          tries;
      int          idx;
      write_reg(alut_addr(`ALUT_MAC_LO), mac[31:0]);
      write_reg(alut_addr(`ALUT_MAC_HI), 32'(mac[47:32]));
      write_reg(alut_addr(`ALUT_CMD), 32'h2);
      tries = 0;
      read_reg(alut_addr(`ALUT_CMD), rd);
      while (rd[0] && tries < POLL_MAX) begin
         tries++;
         read_reg(alut_addr(`ALUT_CMD), rd);
      end
      assert (!rd[0]) else begin
         $display("Lookup of MAC %012h never finished, busy still set", mac);
         errors++;
      end
      read_reg(alut_addr(`ALUT_RESULT), rd);
      idx = ref_find(mac);
      check_val("result hit", 32'(rd[2]), (idx >= 0) ? 32'd1 : 32'd0);
      if (idx >= 0) check_val("result port", 32'(rd[1:0]), 32'(ref_port[idx]));
   endtask

   // --------------------
   // Bus monitor
   // --------------------
   always @(negedge hclk) begin
      if (!rst && in_xfer) begin
         // One MAC select at most, the addressed one
         assert (psel_vec == exp_psel) else begin
            $display("[ERROR] %0t psel_mac: got %b expected %b", $time, psel_vec, exp_psel);
            errors++;
         end
         // ALUT select only inside its own range
         assert (uut.psel_alut == exp_alut) else begin
            $display("[ERROR] %0t psel_alut: got %b expected %b", $time,
                     uut.psel_alut, exp_alut);
            errors++;
         end
         // Access cycle carries the AHB address and direction
         if (penable) begin
            assert (paddr == exp_addr) else begin
               $display("[ERROR] %0t paddr: got 0x%08h expected 0x%08h", $time,
                        paddr, exp_addr);
               errors++;
            end
            assert (pwrite == exp_write) else begin
               $display("[ERROR] %0t pwrite: got %b expected %b", $time, pwrite, exp_write);
               errors++;
            end
         end
         // Wait states hold hready low
         if (penable && psel_vec != 4'b0000) begin
            assert (hready == ((psel_vec & pready_vec) != 4'b0000)) else begin
               $display("[ERROR] %0t hready: got %b expected %b", $time, hready,
                        (psel_vec & pready_vec) != 4'b0000);
               errors++;
            end
         end
      end else if (!rst) begin
         assert (psel_vec == 4'b0000 && !uut.psel_alut && !penable) else begin
            $display("APB select or enable active with no transfer in progress");
            errors++;
         end
      end
   end

   // --------------------
   // Tests
   // --------------------
   initial begin
      logic [31:0] rd;
      logic [31:0] wd;
      logic [31:0] addr;
      logic [1:0]  resp;
      logic [47:0] mac;
      void'($urandom(SEED));
      rst       = 1'b1;
      hsel      = 1'b0;
      haddr     = 32'h0;
      htrans    = IDLE;
      hwrite    = 1'b0;
      hwdata    = 32'h0;
      hready_in = 1'b1;
      repeat (4) @(posedge hclk);
      #1;
      rst = 1'b0;

      // Reset values
      @(negedge hclk);
      check_val("hready", 32'(hready), 32'd1);
      check_val("hresp", 32'(hresp), 32'(RESP_OKAY));
      check_val("psel_mac", 32'(psel_vec), 32'd0);
      check_val("psel_alut", 32'(uut.psel_alut), 32'd0);
      check_val("penable", 32'(penable), 32'd0);
      @(posedge hclk);
      #1;
      read_reg(alut_addr(`ALUT_COUNT), rd);
      check_val("count", rd, 32'd0);
      end_test("reset values");

      // Operand registers with their widths
      wd = $urandom;
      write_reg(alut_addr(`ALUT_MAC_LO), wd);
      read_reg(alut_addr(`ALUT_MAC_LO), rd);
      check_val("mac_lo", rd, wd);
      wd = $urandom;
      write_reg(alut_addr(`ALUT_MAC_HI), wd);
      read_reg(alut_addr(`ALUT_MAC_HI), rd);
      check_val("mac_hi", rd, wd & 32'h0000_FFFF);
      wd = $urandom;
      write_reg(alut_addr(`ALUT_PORT), wd);
      read_reg(alut_addr(`ALUT_PORT), rd);
      check_val("port", rd, wd & 32'h0000_0003);
      end_test("register read-back");

      // Learn three, look each up, plus one unknown
      alut_learn(48'h0011_2233_4455, 2'd1);
      alut_learn(48'h00AA_BBCC_DDEE, 2'd2);
      alut_learn(48'h1234_5678_9ABC, 2'd3);
      alut_lookup_check(48'h0011_2233_4455);
      alut_lookup_check(48'h00AA_BBCC_DDEE);
      alut_lookup_check(48'h1234_5678_9ABC);
      alut_lookup_check(48'h0F0F_0F0F_0F0F);
      end_test("learn and lookup");

      // Random offsets inside each MAC range
      for (int s = 0; s < 4; s++) begin
         for (int i = 0; i < 6; i++) begin
            addr = `SLOT1_BASE + 32'(s) * 32'h0001_0000 + ($urandom & 32'h0000_FFFC);
            wd   = $urandom;
            write_reg(addr, wd);
            addr = `SLOT1_BASE + 32'(s) * 32'h0001_0000 + ($urandom & 32'h0000_FFFC);
            read_reg(addr, rd);
            check_val("mac prdata", rd, wd ^ 32'(s + 1));
         end
      end
      end_test("MAC slots");

      // Holes in the map, above, below and far off
      ahb_xfer(1'b1, 32'h00A5_0000, $urandom, rd, resp);
      check_val("hresp", 32'(resp), 32'(RESP_ERROR));
      ahb_xfer(1'b0, 32'h009F_FFFC, 32'h0, rd, resp);
      check_val("hresp", 32'(resp), 32'(RESP_ERROR));
      ahb_xfer(1'b0, 32'hFFFF_0010, 32'h0, rd, resp);
      check_val("hresp", 32'(resp), 32'(RESP_ERROR));
      end_test("unmapped addresses");

      // Overfill, then move an existing MAC to a new port
      for (int i = 0; i < `ALUT_DEPTH + 2; i++) begin
         mac = {16'h5E00, 32'(i) * 32'h0101_0101 + 32'h0A0B_0C0D};
         alut_learn(mac, 2'(i));
      end
      read_reg(alut_addr(`ALUT_COUNT), rd);
      check_val("count", rd, 32'(`ALUT_DEPTH));
      for (int i = 0; i < `ALUT_DEPTH + 2; i++) begin
         mac = {16'h5E00, 32'(i) * 32'h0101_0101 + 32'h0A0B_0C0D};
         alut_lookup_check(mac);
      end
      alut_learn(48'h0011_2233_4455, 2'd0);
      read_reg(alut_addr(`ALUT_COUNT), rd);
      check_val("count", rd, 32'(`ALUT_DEPTH));
      alut_lookup_check(48'h0011_2233_4455);
      end_test("full table");

      $display("%0d tests, %0d checks, %0d errors, %0d transfers",
               tests, checks, errors, xfer_count);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // 20 cycles per transfer covers setup, wait states and the idle gap
   initial begin
      #(MAX_XFERS * 20 * CLK_PERIOD);
      $display("Watchdog expired after %0d transfers, run did not finish", xfer_count);
      $display("Verification failed");
      $finish;
   end

endmodule

//--- sim.f
+incdir+.
apb_sub_pkg.sv
ahb_apb_bridge.sv
alut_regs.sv
alut_table.sv
apb_subsystem.sv
tb_mac_model.sv
tb_apb_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_apb_subsystem \
   -f sim.f -o tb_apb_subsystem || { echo "Build error"; exit 1; }
./obj_dir/tb_apb_subsystem > sim.log 2>&1 || { cat sim.log; echo "Run error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && echo "Simulation FAILED" && exit 1
grep -q "Verification passed" sim.log || { echo "No result in log"; exit 1; }
echo "Simulation PASSED"
exit 0
